// ==== ts2asi.f ====
asi_pkg.sv
ts_byte_capture.sv
asi_fifo.sv
enc_8b10b.sv
asi_tx_framer.sv
asi_serializer.sv
ts2asi_top.sv
tb_asi_rx.sv
tb_ts2asi.sv

// ==== Makefile ====
# Verilator build for the DVB-ASI transmit path

VERILATOR ?= verilator
TOP       ?= tb_ts2asi
RTL_TOP   ?= ts2asi_top
FILELIST  ?= ts2asi.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_ts2asi.sv ====
`default_nettype none

module tb_ts2asi;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FIFO_DEPTH = 16;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       valid;
	logic       sync;
	logic [7:0] data;
	logic       asi_out_p;
	logic       asi_out_n;
	logic [asi_pkg::CNT_W-1:0] sync_err_count;
	logic [asi_pkg::CNT_W-1:0] drop_count;

	// Receiver events
	logic       locked;
	logic       sym_valid;
	logic       sym_k;
	logic [7:0] sym_byte;
	logic       sym_err;
	logic       sym_rd_neg;
	logic       pair_err;

	integer      seed;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	bit          timed_out = 1'b0;
	int unsigned cyc = 0;

	// Scoreboard and decoded bytes
	logic [7:0] exp_q [$];
	logic [7:0] got_q [$];

	int          comma_count = 0;
	int          viol_count = 0;
	int          alt_err_count = 0;
	int          k_err_count = 0;
	int          pair_err_count = 0;
	bit          prev_comma = 1'b0;
	bit          prev_neg = 1'b0;
	int unsigned last_sym_cyc = 0;

	ts2asi_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.valid          (valid),
		.sync           (sync),
		.data           (data),
		.asi_out_p      (asi_out_p),
		.asi_out_n      (asi_out_n),
		.sync_err_count (sync_err_count),
		.drop_count     (drop_count)
	);

	tb_asi_rx rx0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.asi_p      (asi_out_p),
		.asi_n      (asi_out_n),
		.locked     (locked),
		.sym_valid  (sym_valid),
		.sym_k      (sym_k),
		.sym_byte   (sym_byte),
		.sym_err    (sym_err),
		.sym_rd_neg (sym_rd_neg),
		.pair_err   (pair_err)
	);

	// 100 ns clock
	always #50 clk = ~clk;

	// Rising edge index, read at the falling edge
	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	////////////////////
	// Line monitor
	////////////////////

	always @(negedge clk) begin
		if (pair_err) begin
			pair_err_count++;
		end
		if (sym_valid) begin
			last_sym_cyc = cyc;
			// K28.5 always flips disparity, so back to back commas swap form
			if (sym_k && prev_comma && prev_neg == sym_rd_neg) begin
				alt_err_count++;
			end
			if (sym_err) begin
				viol_count++;
			end else if (sym_k) begin
				if (sym_byte != asi_pkg::K28_5) begin
					k_err_count++;
				end
				comma_count++;
			end else begin
				got_q.push_back(sym_byte);
			end
			prev_comma = sym_k;
			prev_neg   = sym_rd_neg;
		end
	end

	////////////////////
	// Checks and waits
	////////////////////

	task automatic compare_value(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			$display("mismatch %s expected %0d actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic confirm(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("error: %s", what);
			errors++;
		end
	endtask

	task automatic wait_lock(input int limit);
		int i;
		i = 0;
		while (!locked && i < limit) begin
			@(negedge clk);
			i++;
		end
		if (!locked) begin
			$display("timeout: receiver found no comma within %0d clocks", limit);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_commas(input int target, input int limit);
		int i;
		i = 0;
		while (comma_count < target && i < limit) begin
			@(negedge clk);
			i++;
		end
		if (comma_count < target) begin
			$display("timeout: only %0d of %0d commas seen", comma_count, target);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_bytes(input int n, input int limit);
		int i;
		i = 0;
		while (got_q.size() < n && i < limit) begin
			@(negedge clk);
			i++;
		end
		if (got_q.size() < n) begin
			$display("timeout: %0d of %0d bytes decoded", got_q.size(), n);
			timed_out = 1'b1;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	// One valid cycle, driven on the falling edge
	task automatic send_byte(input logic [7:0] b, input bit s);
		@(negedge clk);
		valid = 1'b1;
		sync  = s;
		data  = b;
		@(negedge clk);
		valid = 1'b0;
		sync  = 1'b0;
	endtask

	// Twelve clocks per byte, slower than the symbol rate
	task automatic send_paced(input logic [7:0] b, input bit s);
		exp_q.push_back(b);
		send_byte(b, s);
		idle(10);
	endtask

	task automatic match_stream(input string name);
		logic [7:0] e;
		logic [7:0] g;
		int         c0;
		wait_bytes(exp_q.size(), exp_q.size() * 15 + 100);
		while (exp_q.size() > 0 && got_q.size() > 0) begin
			e = exp_q.pop_front();
			g = got_q.pop_front();
			compare_value(name, int'(e), int'(g));
		end
		exp_q.delete();
		// Idle symbols to catch stray bytes
		c0 = comma_count;
		wait_commas(c0 + 3, 100);
		confirm(got_q.size() == 0, "extra bytes decoded after the expected stream");
		got_q.delete();
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before && !timed_out) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic idle_line();
		int e0;
		int c0;
		e0 = errors;
		wait_lock(40);
		confirm(locked, "receiver did not lock on a comma after reset");
		c0 = comma_count;
		wait_commas(c0 + 20, 250);
		confirm(got_q.size() == 0, "data byte decoded on an idle line");
		confirm(viol_count == 0, "code or disparity violation on an idle line");
		confirm(alt_err_count == 0, "back to back commas did not alternate disparity");
		confirm(k_err_count == 0, "control character other than K28.5 seen");
		confirm(pair_err_count == 0, "serial pair outputs not complementary");
		end_test("idle_line", e0);
	endtask

	task automatic paced_order();
		int e0;
		int v0;
		int i;
		e0 = errors;
		v0 = viol_count;
		for (i = 0; i < 20; i++) begin
			send_paced(8'($random(seed)), 1'b0);
		end
		match_stream("paced_order");
		confirm(viol_count == v0, "violation between paced bytes");
		end_test("paced_order", e0);
	endtask

	task automatic all_values();
		int e0;
		int v0;
		int a0;
		int v;
		e0 = errors;
		v0 = viol_count;
		a0 = alt_err_count;
		for (v = 0; v < 256; v++) begin
			send_paced(8'(v), 1'b0);
		end
		match_stream("all_values");
		confirm(viol_count == v0, "code or disparity violation over all byte values");
		confirm(alt_err_count == a0, "comma disparity broken over all byte values");
		end_test("all_values", e0);
	endtask

	task automatic burst_overflow();
		int          e0;
		int          d0;
		int          occ;
		int          drops;
		int          i;
		int unsigned pop_phase;
		bit          popped;
		logic [7:0]  b;
		e0    = errors;
		d0    = int'(drop_count);
		occ   = 0;
		drops = 0;
		// Pop edge is 13 clocks before a symbol completes at the receiver
		pop_phase = (last_sym_cyc + 7) % 10;
		for (i = 0; i < 40; i++) begin
			@(negedge clk);
			b     = 8'($random(seed));
			valid = 1'b1;
			sync  = 1'b0;
			data  = b;
			// Occupancy model for the coming rising edge
			popped = (((cyc + 1) % 10) == pop_phase) && (occ > 0);
			if (occ == FIFO_DEPTH) begin
				drops++;
			end else begin
				occ++;
				exp_q.push_back(b);
			end
			if (popped) begin
				occ--;
			end
		end
		@(negedge clk);
		valid = 1'b0;
		confirm(drops > 0, "burst did not overfill the buffer");
		compare_value("burst_drops", drops, int'(drop_count) - d0);
		match_stream("burst_bytes");
		end_test("burst_overflow", e0);
	endtask

	task automatic sync_errors();
		int         e0;
		int         s0;
		int         p;
		int         i;
		logic [7:0] b;
		e0 = errors;
		s0 = int'(sync_err_count);
		// Well formed packet starts
		for (p = 0; p < 3; p++) begin
			send_paced(asi_pkg::SYNC_BYTE, 1'b1);
			for (i = 0; i < 3; i++) begin
				send_paced(8'($random(seed)), 1'b0);
			end
		end
		match_stream("sync_good_bytes");
		compare_value("sync_good_count", s0, int'(sync_err_count));
		// Strobes on the wrong byte
		for (p = 0; p < 3; p++) begin
			b = 8'($random(seed));
			if (b == asi_pkg::SYNC_BYTE) begin
				b = ~b;
			end
			send_paced(b, 1'b1);
		end
		match_stream("sync_bad_bytes");
		compare_value("sync_bad_count", s0 + 3, int'(sync_err_count));
		end_test("sync_errors", e0);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rst_n = 1'b0;
		valid = 1'b0;
		sync  = 1'b0;
		data  = 8'h00;
		seed  = 51167;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		idle_line();
		if (!timed_out) begin
			paced_order();
		end
		if (!timed_out) begin
			all_values();
		end
		if (!timed_out) begin
			burst_overflow();
		end
		if (!timed_out) begin
			sync_errors();
		end
		$display("tests %0d, checks %0d, errors %0d, timeout %0d",
			tests, checks, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_asi_rx.sv ====
`default_nettype none

module tb_asi_rx (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        asi_p,
	input  wire        asi_n,
	output logic       locked,
	output logic       sym_valid,
	output logic       sym_k,
	output logic [7:0] sym_byte,
	output logic       sym_err,
	output logic       sym_rd_neg,
	output logic       pair_err
);
	timeunit 1ns;
	timeprecision 1ps;

	////////////////////
	// Code tables
	////////////////////

	// 5b6b RD- forms, abcdei with a as MSB
	localparam logic [5:0] T6 [32] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
	};

	// 3b4b RD- forms, fghj with f as MSB, primary 7
	localparam logic [3:0] T4 [8] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
	};

	// Found flag in bit 5, x in the low bits
	function automatic logic [5:0] find6(input logic [5:0] r);
		logic [5:0] i;
		find6 = 6'd0;
		for (i = 0; i < 32; i++) begin
			// Balanced codes have one form, except D.07
			if (r == T6[i[4:0]] || (r == ~T6[i[4:0]]
				&& ($countones(T6[i[4:0]]) != 3 || i == 7))) begin
				find6 = {1'b1, i[4:0]};
			end
		end
	endfunction

	// Found flag in bit 3, y in the low bits
	function automatic logic [3:0] find4(input logic [3:0] r);
		logic [3:0] j;
		find4 = 4'd0;
		// Alternate 7 in either polarity
		if (r == 4'b0111 || r == 4'b1000) begin
			find4 = 4'b1111;
		end
		for (j = 0; j < 8; j++) begin
			if (r == T4[j[2:0]] || (r == ~T4[j[2:0]]
				&& ($countones(T4[j[2:0]]) != 2 || j == 3))) begin
				find4 = {1'b1, j[2:0]};
			end
		end
	endfunction

	////////////////////
	// Align and decode
	////////////////////

	logic [9:0] win;
	logic [3:0] bit_cnt;
	logic       rd_pos;

	always @(posedge clk) begin : rx_shift
		logic [9:0] w;
		logic [5:0] r6;
		logic [3:0] r4;
		logic [5:0] f6;
		logic [3:0] f4;
		logic       rd;
		logic       bad;
		logic       is_k;
		int         n6;
		int         n4;
		// Bit a arrives first and ends up in w[0]
		w    = {asi_p, win[9:1]};
		r6   = {w[0], w[1], w[2], w[3], w[4], w[5]};
		r4   = {w[6], w[7], w[8], w[9]};
		is_k = (r6 == 6'b001111) || (r6 == 6'b110000);
		sym_valid <= 1'b0;
		if (!rst_n) begin
			win      <= '0;
			bit_cnt  <= '0;
			locked   <= 1'b0;
			rd_pos   <= 1'b0;
			pair_err <= 1'b0;
			sym_k    <= 1'b0;
			sym_byte <= '0;
			sym_err  <= 1'b0;
			sym_rd_neg <= 1'b1;
		end else begin
			pair_err <= (asi_p == asi_n);
			win      <= w;
			if (!locked) begin
				// Full K28.5 in either disparity
				if ((r6 == 6'b001111 && r4 == 4'b1010) || (r6 == 6'b110000 && r4 == 4'b0101)) begin
					locked     <= 1'b1;
					bit_cnt    <= '0;
					sym_valid  <= 1'b1;
					sym_k      <= 1'b1;
					sym_byte   <= 8'hBC;
					sym_err    <= 1'b0;
					sym_rd_neg <= (r6 == 6'b001111);
					rd_pos     <= (r6 == 6'b001111);
				end
			end else if (bit_cnt == 4'd9) begin
				bit_cnt <= '0;
				rd  = rd_pos;
				bad = 1'b0;
				n6  = $countones(r6);
				n4  = $countones(r4);
				// Heavy block only from RD-, light block only from RD+
				if (n6 == 4 && !rd) begin
					rd = 1'b1;
				end else if (n6 == 2 && rd) begin
					rd = 1'b0;
				end else if (n6 != 3) begin
					bad = 1'b1;
				end
				if (n4 == 3 && !rd) begin
					rd = 1'b1;
				end else if (n4 == 1 && rd) begin
					rd = 1'b0;
				end else if (n4 != 2) begin
					bad = 1'b1;
				end
				f6 = is_k ? 6'b111100 : find6(r6);
				// K28 from RD+ carries an inverted 3b4b block
				f4 = find4((r6 == 6'b110000) ? ~r4 : r4);
				if (!f6[5] || !f4[3]) begin
					bad = 1'b1;
				end
				sym_valid  <= 1'b1;
				sym_k      <= is_k;
				sym_byte   <= {f4[2:0], f6[4:0]};
				sym_err    <= bad;
				// Commas report the form seen on the line
				sym_rd_neg <= is_k ? (r6 == 6'b001111) : !rd_pos;
				rd_pos     <= rd;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== ts2asi_top.sv ====
`default_nettype none

module ts2asi_top #(
	parameter int FIFO_DEPTH = 16
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           valid,
	input  wire                           sync,
	input  wire  [7:0]                    data,
	output logic                          asi_out_p,
	output logic                          asi_out_n,
	output logic [asi_pkg::CNT_W-1:0]     sync_err_count,
	output logic [asi_pkg::CNT_W-1:0]     drop_count
);

	////////////////////
	// Interconnect
	////////////////////

	logic               wr_en;
	asi_pkg::asi_word_t wr_word;
	logic               rd_en;
	asi_pkg::asi_word_t rd_word;
	logic               full;
	logic               empty;
	asi_pkg::asi_word_t enc_word;
	logic               enc_ce;
	logic               ser_load;
	logic [9:0]         code;

	// Input side, sync check and overflow count
	ts_byte_capture u_capture (
		.clk            (clk),
		.rst_n          (rst_n),
		.valid          (valid),
		.sync           (sync),
		.data           (data),
		.full           (full),
		.wr_en          (wr_en),
		.wr_word        (wr_word),
		.sync_err_count (sync_err_count),
		.drop_count     (drop_count)
	);

	asi_fifo #(
		.word_t     (asi_pkg::asi_word_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_word (wr_word),
		.rd_en   (rd_en),
		.rd_word (rd_word),
		.full    (full),
		.empty   (empty)
	);

	// Symbol rate side
	asi_tx_framer u_framer (
		.clk      (clk),
		.rst_n    (rst_n),
		.empty    (empty),
		.rd_word  (rd_word),
		.rd_en    (rd_en),
		.enc_word (enc_word),
		.enc_ce   (enc_ce),
		.ser_load (ser_load)
	);

	enc_8b10b u_enc (
		.clk     (clk),
		.rst_n   (rst_n),
		.ce      (enc_ce),
		.word_in (enc_word),
		.code    (code)
	);

	asi_serializer u_ser (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (ser_load),
		.code      (code),
		.asi_out_p (asi_out_p),
		.asi_out_n (asi_out_n)
	);

endmodule

`default_nettype wire

// ==== asi_serializer.sv ====
`default_nettype none

module asi_serializer (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire                              load,
	input  wire [asi_pkg::SYMBOL_BITS-1:0]   code,
	output logic                             asi_out_p,
	output logic                             asi_out_n
);

	// K28.5 RD+ form, leaves the line at RD- for the encoder
	localparam logic [asi_pkg::SYMBOL_BITS-1:0] COMMA_RDP = 10'b1010000011;

	logic [asi_pkg::SYMBOL_BITS-1:0] shreg;

	// Load a symbol, else shift right, LSB leaves first
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shreg <= COMMA_RDP;
		end else if (load) begin
			shreg <= code;
		end else begin
			shreg <= {1'b0, shreg[asi_pkg::SYMBOL_BITS-1:1]};
		end
	end

	// Registered pair, always complementary
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			asi_out_p <= 1'b0;
			asi_out_n <= 1'b1;
		end else begin
			asi_out_p <= shreg[0];
			asi_out_n <= ~shreg[0];
		end
	end

endmodule

`default_nettype wire

// ==== asi_tx_framer.sv ====
`default_nettype none

module asi_tx_framer (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                empty,
	input  asi_pkg::asi_word_t rd_word,
	output logic               rd_en,
	output asi_pkg::asi_word_t enc_word,
	output logic               enc_ce,
	output logic               ser_load
);

	localparam int SYM_CNT_W = $clog2(asi_pkg::SYMBOL_BITS);

	// Last count of a symbol period
	localparam logic [SYM_CNT_W-1:0] CNT_LAST = SYM_CNT_W'(asi_pkg::SYMBOL_BITS - 1);

	// Start phase lines the first load up with the end of the
	// reset comma held in the serializer, so the line has no gap
	localparam logic [SYM_CNT_W-1:0] CNT_START = SYM_CNT_W'(2);

	// Comma filler for an idle buffer
	localparam asi_pkg::asi_word_t COMMA = '{k: 1'b1, data: asi_pkg::K28_5};

	logic [SYM_CNT_W-1:0] sym_cnt;
	logic                 sym_strobe;

	////////////////////
	// Symbol timing
	////////////////////

	// One clock in ten
	assign sym_strobe = (sym_cnt == CNT_LAST);

	// Pop only when something is waiting
	assign rd_en = sym_strobe & ~empty;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sym_cnt  <= CNT_START;
			enc_ce   <= 1'b0;
			ser_load <= 1'b0;
		end else begin
			if (sym_strobe) begin
				sym_cnt <= '0;
			end else begin
				sym_cnt <= sym_cnt + 1'b1;
			end
			// Encode one clock later, load one more after that
			enc_ce   <= sym_strobe;
			ser_load <= enc_ce;
		end
	end

	////////////////////
	// Word select
	////////////////////

	// Head word or comma, held for the encoder
	always_ff @(posedge clk) begin
		if (sym_strobe) begin
			if (empty) begin
				enc_word <= COMMA;
			end else begin
				enc_word <= rd_word;
			end
		end
	end

endmodule

`default_nettype wire

// ==== enc_8b10b.sv ====
`default_nettype none

module enc_8b10b (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                ce,
	input  asi_pkg::asi_word_t word_in,
	output logic [9:0]         code
);

	////////////////////
	// Code tables
	////////////////////

	// 5b6b, RD- column, written abcdei with a in bit 5
	function automatic logic [5:0] lut_5b6b(input logic [4:0] x);
		case (x)
			5'd0:  lut_5b6b = 6'b100111;
			5'd1:  lut_5b6b = 6'b011101;
			5'd2:  lut_5b6b = 6'b101101;
			5'd3:  lut_5b6b = 6'b110001;
			5'd4:  lut_5b6b = 6'b110101;
			5'd5:  lut_5b6b = 6'b101001;
			5'd6:  lut_5b6b = 6'b011001;
			5'd7:  lut_5b6b = 6'b111000;
			5'd8:  lut_5b6b = 6'b111001;
			5'd9:  lut_5b6b = 6'b100101;
			5'd10: lut_5b6b = 6'b010101;
			5'd11: lut_5b6b = 6'b110100;
			5'd12: lut_5b6b = 6'b001101;
			5'd13: lut_5b6b = 6'b101100;
			5'd14: lut_5b6b = 6'b011100;
			5'd15: lut_5b6b = 6'b010111;
			5'd16: lut_5b6b = 6'b011011;
			5'd17: lut_5b6b = 6'b100011;
			5'd18: lut_5b6b = 6'b010011;
			5'd19: lut_5b6b = 6'b110010;
			5'd20: lut_5b6b = 6'b001011;
			5'd21: lut_5b6b = 6'b101010;
			5'd22: lut_5b6b = 6'b011010;
			5'd23: lut_5b6b = 6'b111010;
			5'd24: lut_5b6b = 6'b110011;
			5'd25: lut_5b6b = 6'b100110;
			5'd26: lut_5b6b = 6'b010110;
			5'd27: lut_5b6b = 6'b110110;
			5'd28: lut_5b6b = 6'b001110;
			5'd29: lut_5b6b = 6'b101110;
			5'd30: lut_5b6b = 6'b011110;
			default: lut_5b6b = 6'b101011;
		endcase
	endfunction

	// 3b4b, RD- column, fghj with f in bit 3; primary 7 only
	function automatic logic [3:0] lut_3b4b(input logic [2:0] y);
		case (y)
			3'd0: lut_3b4b = 4'b1011;
			3'd1: lut_3b4b = 4'b1001;
			3'd2: lut_3b4b = 4'b0101;
			3'd3: lut_3b4b = 4'b1100;
			3'd4: lut_3b4b = 4'b1101;
			3'd5: lut_3b4b = 4'b1010;
			3'd6: lut_3b4b = 4'b0110;
			default: lut_3b4b = 4'b1110;
		endcase
	endfunction

	////////////////////
	// Encode
	////////////////////

	logic       rd_pos;
	logic       rd_blk;
	logic       rd_nxt;
	logic [4:0] x;
	logic [2:0] y;
	logic       is_k28;
	logic [5:0] s6;
	logic [3:0] s4;
	logic       unbal6;
	logic       unbal4;
	logic       alt7;
	logic       flip6;
	logic       flip4;
	logic [5:0] o6;
	logic [3:0] o4;

	always_comb begin
		x      = word_in.data[4:0];
		y      = word_in.data[7:5];
		is_k28 = word_in.k && (x == 5'd28);
		s6     = is_k28 ? 6'b001111 : lut_5b6b(x);
		unbal6 = ($countones(s6) != 3);
		// D.07 is balanced but still has two forms
		flip6  = rd_pos & (unbal6 | (s6 == 6'b111000));
		// Disparity seen by the 3b4b block
		rd_blk = rd_pos ^ unbal6;
		// Alternate 7 avoids a run of five in the middle
		alt7 = (y == 3'd7) && (is_k28
			|| (!rd_blk && ((x == 5'd17) || (x == 5'd18) || (x == 5'd20)))
			|| (rd_blk && ((x == 5'd11) || (x == 5'd13) || (x == 5'd14))));
		s4     = alt7 ? 4'b0111 : lut_3b4b(y);
		unbal4 = ($countones(s4) != 2);
		// Balanced K28 forms invert against the data forms
		if (unbal4) begin
			flip4 = rd_blk;
		end else if (is_k28) begin
			flip4 = ~rd_blk ^ (y == 3'd3);
		end else begin
			flip4 = rd_blk & (y == 3'd3);
		end
		o6     = s6 ^ {6{flip6}};
		o4     = s4 ^ {4{flip4}};
		rd_nxt = rd_blk ^ unbal4;
	end

	// Send order a first, so a lands in bit 0
	always_ff @(posedge clk) begin
		if (ce) begin
			code <= {o4[0], o4[1], o4[2], o4[3], o6[0], o6[1], o6[2], o6[3], o6[4], o6[5]};
		end
	end

	// Running disparity, negative out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_pos <= 1'b0;
		end else if (ce) begin
			rd_pos <= rd_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== asi_fifo.sv ====
`default_nettype none

module asi_fifo #(
	parameter type word_t     = logic [7:0],
	parameter int  FIFO_DEPTH = 16
) (
	input  wire   clk,
	input  wire   rst_n,
	input  wire   wr_en,
	input  word_t wr_word,
	input  wire   rd_en,
	output word_t rd_word,
	output logic  full,
	output logic  empty
);

	// Address bits, depth is a power of two
	localparam int AW = $clog2(FIFO_DEPTH);

	////////////////////
	// Storage
	////////////////////

	word_t mem [FIFO_DEPTH];

	// Extra MSB tells a wrapped write pointer from an equal one
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	logic do_wr;
	logic do_rd;

	// Ignore writes when full and reads when empty
	assign do_wr = wr_en & ~full;
	assign do_rd = rd_en & ~empty;

	// Same address, opposite lap
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign empty = (wr_ptr == rd_ptr);

	// Head word is always visible (fall-through)
	assign rd_word = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr[AW-1:0]] <= wr_word;
		end
	end

	////////////////////
	// Pointers
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== ts_byte_capture.sv ====
`default_nettype none

module ts_byte_capture (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           valid,
	input  wire                           sync,
	input  wire  [7:0]                    data,
	input  wire                           full,
	output logic                          wr_en,
	output asi_pkg::asi_word_t            wr_word,
	output logic [asi_pkg::CNT_W-1:0]     sync_err_count,
	output logic [asi_pkg::CNT_W-1:0]     drop_count
);

	logic sync_bad;
	logic drop;

	// Data path is straight through, written at the sampling edge
	assign wr_word = '{k: 1'b0, data: data};
	assign wr_en   = valid & ~full;

	// Sync strobe landing on anything but 0x47
	assign sync_bad = valid & sync & (data != asi_pkg::SYNC_BYTE);

	// Byte lost to a full buffer
	assign drop = valid & full;

	// Both counters stick at all ones
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_err_count <= '0;
			drop_count     <= '0;
		end else begin
			if (sync_bad && (sync_err_count != '1)) begin
				sync_err_count <= sync_err_count + 1'b1;
			end
			if (drop && (drop_count != '1)) begin
				drop_count <= drop_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== asi_pkg.sv ====
`default_nettype none

package asi_pkg;

	////////////////////
	// Word format
	////////////////////

	// One buffered symbol: control flag plus the byte
	typedef struct packed {
		logic       k;
		logic [7:0] data;
	} asi_word_t;

	// Comma byte, sent with k set (K28.5)
	localparam logic [7:0] K28_5 = 8'hBC;

	// MPEG-TS packet sync byte
	localparam logic [7:0] SYNC_BYTE = 8'h47;

	////////////////////
	// Sizes
	////////////////////

	// Width of the saturating error counters
	localparam int CNT_W = 16;

	// Bits per 8b10b symbol, also the clocks per symbol
	localparam int SYMBOL_BITS = 10;

endpackage

`default_nettype wire
